/* hps_readout.f */
hw/readout_pkg.sv
hw/board_ctl_pkg.sv
hw/sample_latch.sv
hw/readout_ctrl.sv
hw/reset_pulse_gen.sv
hw/key_debounce.sv
hw/hps_readout_top.sv
sim/tb_hps_readout.sv

/* hw/board_ctl_pkg.sv */
/*
  Board control definitions. Holds the HPS reset request pulse lengths,
  the key debounce timing and the reset kind encoding, which also gives
  the bit of each kind in the reset request vector.
*/
`default_nettype none

package board_ctl_pkg;

  // reset request pulse lengths, in 80 MHz cycles
  localparam int cold_pulse_cycles  = 6;
  localparam int warm_pulse_cycles  = 2;
  localparam int debug_pulse_cycles = 32;
  localparam int pulse_cnt_w        = 6;  // holds up to 63

  // key debounce, 1 ms at 80 MHz
  localparam int debounce_cycles = 80000;
  localparam int debounce_cnt_w  = 17;
  localparam int key_w           = 2;   // KEY[1:0], active low

  // reset kind, also the index into reset_req
  typedef enum logic [1:0] {
    rst_cold  = 2'd0,
    rst_warm  = 2'd1,
    rst_debug = 2'd2
  } reset_kind_e;

endpackage

`default_nettype wire

/* hw/hps_readout_top.sv */
/*
  FPGA side logic around the HPS. Connects the ADC sample latch to the
  readout control that serves the HPS command word, builds the cold, warm
  and debug reset request pulses and debounces the board keys. Everything
  runs on CLOCK_80MHZ.
*/
`timescale 1ns/1ps
`default_nettype none

module hps_readout_top
  import readout_pkg::*;
  import board_ctl_pkg::*;
#(
  parameter int DEBOUNCE_CYCLES = debounce_cycles
)
(
  input  wire logic                CLOCK_80MHZ,
  input  wire logic                hps_fpga_reset_n,
  // adc sample path
  input  wire logic                new_data,
  input  wire logic [adc_w-1:0]    adc_value,
  input  wire logic [time_w-1:0]   adc_time,
  // hps readout port
  input  wire logic [word_w-1:0]   hps_cmd,
  input  wire logic [offset_w-1:0] trig_offset,
  input  wire logic [hv_w-1:0]     high_voltage,
  input  wire logic [offset_w-1:0] mean_offset,
  output logic      [word_w-1:0]   to_hps,
  // reset requests, one bit per reset kind
  input  wire logic [2:0]          reset_req,
  output logic                     cold_reset_req_n,
  output logic                     warm_reset_req_n,
  output logic                     debug_reset_req_n,
  // keys
  input  wire logic [key_w-1:0]    key,
  output logic      [key_w-1:0]    key_clean
);

  logic              sample_valid;
  logic              sample_ready;
  logic [adc_w-1:0]  sample_value;
  logic [time_w-1:0] sample_time;

  // ==========================================================================
  // sample readout
  // ==========================================================================
  sample_latch sample_latch_i (
    .CLOCK_80MHZ      (CLOCK_80MHZ),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .new_data         (new_data),
    .adc_value        (adc_value),
    .adc_time         (adc_time),
    .sample_ready     (sample_ready),
    .sample_valid     (sample_valid),
    .sample_value     (sample_value),
    .sample_time      (sample_time)
  );

  readout_ctrl readout_ctrl_i (
    .CLOCK_80MHZ      (CLOCK_80MHZ),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .hps_cmd          (hps_cmd),
    .sample_valid     (sample_valid),
    .sample_value     (sample_value),
    .sample_time      (sample_time),
    .trig_offset      (trig_offset),
    .high_voltage     (high_voltage),
    .mean_offset      (mean_offset),
    .sample_ready     (sample_ready),
    .to_hps           (to_hps)
  );

  // ==========================================================================
  // hps reset requests
  // ==========================================================================
  reset_pulse_gen #(.PULSE_CYCLES(cold_pulse_cycles)) cold_pulse_i (  // rst_cold
    .CLOCK_80MHZ      (CLOCK_80MHZ),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req[rst_cold]),
    .reset_req_n      (cold_reset_req_n)
  );

  reset_pulse_gen #(.PULSE_CYCLES(warm_pulse_cycles)) warm_pulse_i (  // rst_warm
    .CLOCK_80MHZ      (CLOCK_80MHZ),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req[rst_warm]),
    .reset_req_n      (warm_reset_req_n)
  );

  reset_pulse_gen #(.PULSE_CYCLES(debug_pulse_cycles)) debug_pulse_i (  // rst_debug
    .CLOCK_80MHZ      (CLOCK_80MHZ),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req[rst_debug]),
    .reset_req_n      (debug_reset_req_n)
  );

  // keys, 1 ms filter at the default length
  key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) key_debounce_i (
    .CLOCK_80MHZ      (CLOCK_80MHZ),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key              (key),
    .key_clean        (key_clean)
  );

endmodule

`default_nettype wire

/* hw/key_debounce.sv */
/*
  Key debouncer for the active low board keys. Each key has its own
  stability counter; the clean output takes the raw level once it has
  differed from the clean level for DEBOUNCE_CYCLES cycles in a row.
  Shorter glitches reset the counter and never reach key_clean.
*/
`timescale 1ns/1ps
`default_nettype none

module key_debounce
  import board_ctl_pkg::*;
#(
  parameter int DEBOUNCE_CYCLES = debounce_cycles
)
(
  input  wire logic             CLOCK_80MHZ,
  input  wire logic             hps_fpga_reset_n,
  input  wire logic [key_w-1:0] key,        // raw, active low
  output logic      [key_w-1:0] key_clean   // filtered, active low
);

  localparam logic [debounce_cnt_w-1:0] cnt_done = debounce_cnt_w'(DEBOUNCE_CYCLES);

  logic [debounce_cnt_w-1:0] stable_cnt [key_w];

  // ==========================================================================
  // one counter per key
  // ==========================================================================
  for (genvar k = 0; k < key_w; k++)
  begin : g_key
    always_ff @(posedge CLOCK_80MHZ or negedge hps_fpga_reset_n)
    begin
      if (!hps_fpga_reset_n)
      begin
        stable_cnt[k] <= '0;
        key_clean[k]  <= 1'b1;  // released
      end
      else if (key[k] == key_clean[k])
        stable_cnt[k] <= '0;    // nothing pending or glitch gone
      else if (stable_cnt[k] == cnt_done)
      begin
        key_clean[k]  <= key[k];  // held long enough
        stable_cnt[k] <= '0;
      end
      else
        stable_cnt[k] <= stable_cnt[k] + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hw/readout_ctrl.sv */
/*
  HPS readout control. Decodes the command word written by the HPS into a
  readout opcode, packs the selected value into the returned word and
  registers it. The falling edge of the ack bit, after it was seen high,
  produces a single cycle sample_ready towards the sample latch.
*/
`timescale 1ns/1ps
`default_nettype none

module readout_ctrl
  import readout_pkg::*;
(
  input  wire logic                CLOCK_80MHZ,
  input  wire logic                hps_fpga_reset_n,
  input  wire logic [word_w-1:0]   hps_cmd,       // command word from HPS
  input  wire logic                sample_valid,
  input  wire logic [adc_w-1:0]    sample_value,
  input  wire logic [time_w-1:0]   sample_time,
  input  wire logic [offset_w-1:0] trig_offset,
  input  wire logic [hv_w-1:0]     high_voltage,
  input  wire logic [offset_w-1:0] mean_offset,
  output logic                     sample_ready,  // one cycle, consumes sample
  output logic [word_w-1:0]        to_hps         // word polled by HPS
);

  typedef enum logic {
    ack_idle,  // waiting for ack bit high
    ack_seen   // ack high, waiting for it to drop
  } ack_state_e;

  ack_state_e            ack_state;
  readout_op_e           op;
  logic                  ack_bit;
  logic                  ack_fall;
  logic [word_w-1:0]     sample_word;

  assign ack_bit     = hps_cmd[cmd_ack_bit];
  assign ack_fall    = (ack_state == ack_seen) && !ack_bit;
  assign sample_word = word_w'({sample_time, 1'b0, sample_value, 1'b1});

  // ==========================================================================
  // command decode, sample > trig > hv > mean
  // ==========================================================================
  always_comb
  begin
    if (hps_cmd[cmd_sample_bit])
      op = op_sample;
    else if (hps_cmd[cmd_trig_bit])
      op = op_trig_offset;
    else if (hps_cmd[cmd_hv_bit])
      op = op_high_voltage;
    else if (hps_cmd[cmd_mean_bit])
      op = op_mean_offset;
    else
      op = op_none;
  end

  // ==========================================================================
  // ack edge tracking
  // ==========================================================================
  always_ff @(posedge CLOCK_80MHZ or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      ack_state    <= ack_idle;
      sample_ready <= 1'b0;
    end
    else
    begin
      sample_ready <= ack_fall;  // high the cycle after the edge
      case (ack_state)
        ack_idle: if (ack_bit)  ack_state <= ack_seen;
        ack_seen: if (!ack_bit) ack_state <= ack_idle;
        default:                ack_state <= ack_idle;
      endcase
    end
  end

  // ==========================================================================
  // returned word register
  // ==========================================================================
  always_ff @(posedge CLOCK_80MHZ or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
      to_hps <= '0;
    else
    begin
      case (op)
        op_sample:
        begin
          // ack low holds the word so the HPS can read it
          if (ack_bit)
            to_hps <= sample_valid ? sample_word : '0;
        end
        op_trig_offset:  to_hps <= word_w'({trig_offset, 1'b1});
        op_high_voltage: to_hps <= word_w'({high_voltage, 1'b1});
        op_mean_offset:  to_hps <= word_w'({mean_offset, 1'b1});
        default:         to_hps <= '0;  // op_none
      endcase
    end
  end

  // one ack edge gives exactly one ready cycle
  ready_single_cycle: assert property (
    @(posedge CLOCK_80MHZ) disable iff (!hps_fpga_reset_n)
    sample_ready |=> !sample_ready
  );

endmodule

`default_nettype wire

/* hw/readout_pkg.sv */
/*
  Readout port definitions shared by the sample latch, the readout control
  and the top level. Field widths, the HPS command word bit positions and
  the readout opcodes live here. Import with readout_pkg::* in the module
  header.
*/
`default_nettype none

package readout_pkg;

  // ==========================================================================
  // field widths
  // ==========================================================================
  localparam int time_w   = 18;  // adc timestamp
  localparam int adc_w    = 12;  // adc sample
  localparam int offset_w = 18;  // trigger offset and mean offset
  localparam int hv_w     = 12;  // high voltage reading
  localparam int word_w   = 32;  // command word and returned word

  // ==========================================================================
  // command word bits written by the HPS
  // ==========================================================================
  localparam int cmd_sample_bit = 0;  // read adc sample
  localparam int cmd_ack_bit    = 1;  // ack strobe, falling edge consumes
  localparam int cmd_trig_bit   = 2;  // read trigger offset
  localparam int cmd_hv_bit     = 3;  // read high voltage
  localparam int cmd_mean_bit   = 4;  // read mean offset

  // sample word is {time, 0, value, 1}, fills the whole word
  localparam int sample_word_w = time_w + 1 + adc_w + 1;

  // readout opcode, decoded from the command word by priority
  typedef enum logic [2:0] {
    op_none         = 3'd0,
    op_sample       = 3'd1,
    op_trig_offset  = 3'd2,
    op_high_voltage = 3'd3,
    op_mean_offset  = 3'd4
  } readout_op_e;

endpackage

`default_nettype wire

/* hw/reset_pulse_gen.sv */
/*
  Reset request pulse generator for the HPS cold, warm and debug reset
  inputs. A rising edge on req drives reset_req_n low for PULSE_CYCLES
  cycles; edges arriving while the pulse runs are ignored.
*/
`timescale 1ns/1ps
`default_nettype none

module reset_pulse_gen
  import board_ctl_pkg::*;
#(
  parameter int PULSE_CYCLES = cold_pulse_cycles
)
(
  input  wire logic CLOCK_80MHZ,
  input  wire logic hps_fpga_reset_n,
  input  wire logic req,          // level request, edge triggered
  output logic      reset_req_n   // active low to HPS
);

  logic                   req_q;   // previous req for edge detect
  logic                   rise;
  logic                   busy;
  logic [pulse_cnt_w-1:0] remain;  // low cycles left after this one

  assign rise = req && !req_q;
  assign busy = !reset_req_n;

  always_ff @(posedge CLOCK_80MHZ or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      req_q       <= 1'b0;
      reset_req_n <= 1'b1;
      remain      <= '0;
    end
    else
    begin
      req_q <= req;
      if (busy)
      begin
        if (remain == '0)
          reset_req_n <= 1'b1;  // pulse done
        else
          remain <= remain - 1'b1;
      end
      else if (rise)
      begin
        reset_req_n <= 1'b0;
        remain      <= pulse_cnt_w'(PULSE_CYCLES - 1);
      end
    end
  end

  // pulse never outlasts its length, retriggers included
  pulse_len_bound: assert property (
    @(posedge CLOCK_80MHZ) disable iff (!hps_fpga_reset_n)
    $fell(reset_req_n) |-> ##[1:PULSE_CYCLES] reset_req_n
  );

endmodule

`default_nettype wire

/* hw/sample_latch.sv */
/*
  Holds the newest ADC sample and its timestamp for the HPS. A new_data
  pulse loads the sample and raises sample_valid; a valid/ready transfer
  with the readout control drops it again. A newer sample always replaces
  a pending one, so the HPS reads the latest conversion.
*/
`timescale 1ns/1ps
`default_nettype none

module sample_latch
  import readout_pkg::*;
(
  input  wire logic              CLOCK_80MHZ,
  input  wire logic              hps_fpga_reset_n,
  input  wire logic              new_data,      // one cycle strobe from adc
  input  wire logic [adc_w-1:0]  adc_value,
  input  wire logic [time_w-1:0] adc_time,
  input  wire logic              sample_ready,  // from readout_ctrl
  output logic                   sample_valid,
  output logic [adc_w-1:0]       sample_value,
  output logic [time_w-1:0]      sample_time
);

  logic xfer;  // sample handed over this cycle

  assign xfer = sample_valid && sample_ready;

  // valid flag, new_data wins over a transfer in the same cycle
  always_ff @(posedge CLOCK_80MHZ or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
      sample_valid <= 1'b0;
    else if (new_data)
      sample_valid <= 1'b1;
    else if (xfer)
      sample_valid <= 1'b0;
  end

  // payload, overwritten by each new sample
  always_ff @(posedge CLOCK_80MHZ)
  begin
    if (new_data)
    begin
      sample_value <= adc_value;
      sample_time  <= adc_time;
    end
  end

  // a sample is only ever dropped through a handshake with readout_ctrl
  valid_drop_needs_ready: assert property (
    @(posedge CLOCK_80MHZ) disable iff (!hps_fpga_reset_n)
    $fell(sample_valid) |-> $past(sample_ready)
  );

endmodule

`default_nettype wire

/* sim/tb_hps_readout.sv */
/*
  Testbench for hps_readout_top. Builds a table of steps at time zero, each
  with the command word, slow values, an optional ADC sample, reset requests,
  key levels, a hold time and the expected outputs, then applies it in a loop.
  Inputs change on the falling clock edge; outputs are checked there too.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_hps_readout
  import readout_pkg::*;
  import board_ctl_pkg::*;
;

  typedef struct packed {
    logic [word_w-1:0]   cmd;
    logic [offset_w-1:0] trig;
    logic [hv_w-1:0]     hv;
    logic [offset_w-1:0] mean;
    logic                nd;         // new_data pulse in the first cycle
    logic [adc_w-1:0]    val;
    logic [time_w-1:0]   tim;
    logic [2:0]          rreq;       // indexed by reset_kind_e
    logic [key_w-1:0]    key;
    logic [7:0]          hold;       // cycles before the check
    logic [word_w-1:0]   exp_hps;
    logic [2:0]          exp_rst_n;  // {debug, warm, cold}
    logic [key_w-1:0]    exp_key;
  } step_t;

  logic                CLOCK_80MHZ;
  logic                hps_fpga_reset_n;
  logic                new_data;
  logic [adc_w-1:0]    adc_value;
  logic [time_w-1:0]   adc_time;
  logic [word_w-1:0]   hps_cmd;
  logic [offset_w-1:0] trig_offset;
  logic [hv_w-1:0]     high_voltage;
  logic [offset_w-1:0] mean_offset;
  logic [word_w-1:0]   to_hps;
  logic [2:0]          reset_req;
  logic                cold_reset_req_n;
  logic                warm_reset_req_n;
  logic                debug_reset_req_n;
  logic [key_w-1:0]    key;
  logic [key_w-1:0]    key_clean;

  step_t       steps[$];
  step_t       cur;             // step under construction
  step_t       st;              // step being applied
  logic [31:0] lcg_state = 32'hba0;
  int          errors = 0;
  int          checks = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;  // set from the table length

  hps_readout_top #(.DEBOUNCE_CYCLES(16)) dut_i (
    .CLOCK_80MHZ       (CLOCK_80MHZ),
    .hps_fpga_reset_n  (hps_fpga_reset_n),
    .new_data          (new_data),
    .adc_value         (adc_value),
    .adc_time          (adc_time),
    .hps_cmd           (hps_cmd),
    .trig_offset       (trig_offset),
    .high_voltage      (high_voltage),
    .mean_offset       (mean_offset),
    .to_hps            (to_hps),
    .reset_req         (reset_req),
    .cold_reset_req_n  (cold_reset_req_n),
    .warm_reset_req_n  (warm_reset_req_n),
    .debug_reset_req_n (debug_reset_req_n),
    .key               (key),
    .key_clean         (key_clean)
  );

  initial
  begin
    CLOCK_80MHZ = 1'b0;
    forever #5 CLOCK_80MHZ = ~CLOCK_80MHZ;  // 10 ns period
  end

  // ==========================================================================
  // stimulus helpers and expected word packing
  // ==========================================================================
  function automatic logic [31:0] lcg_draw();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // value in bits n:1, valid flag in bit 0
  function automatic logic [word_w-1:0] slow_word(input logic [offset_w-1:0] v);
    return {13'b0, v, 1'b1};
  endfunction

  function automatic logic [word_w-1:0] sample_word(input logic [adc_w-1:0] v,
                                                    input logic [time_w-1:0] t);
    return {t, 1'b0, v, 1'b1};
  endfunction

  task automatic new_slow_values();
    cur.trig = offset_w'(lcg_draw() >> 7);
    cur.hv   = hv_w'(lcg_draw() >> 11);
    cur.mean = offset_w'(lcg_draw() >> 5);
  endtask

  task automatic new_sample();
    cur.nd  = 1'b1;
    cur.val = adc_w'(lcg_draw() >> 9);
    cur.tim = time_w'(lcg_draw() >> 3);
  endtask

  task automatic push_step(input logic [7:0] hold_cycles);
    cur.hold = hold_cycles;
    steps.push_back(cur);
    cur.nd = 1'b0;  // one cycle pulse only
  endtask

  // fresh slow values, one command, word of the field that should win
  task automatic slow_read(input logic [word_w-1:0] cmd_word, input readout_op_e want);
    new_slow_values();
    cur.cmd = cmd_word;
    case (want)
      op_trig_offset:  cur.exp_hps = slow_word(cur.trig);
      op_high_voltage: cur.exp_hps = slow_word(offset_w'(cur.hv));
      op_mean_offset:  cur.exp_hps = slow_word(cur.mean);
      default:         cur.exp_hps = '0;
    endcase
    push_step(1);
  endtask

  task automatic req_step(input reset_kind_e kind, input logic lvl, input logic exp_n,
                          input logic [7:0] hold_cycles);
    cur.rreq[kind]      = lvl;
    cur.exp_rst_n[kind] = exp_n;  // level on the matching output
    push_step(hold_cycles);
  endtask

  task automatic key_step(input logic [key_w-1:0] lvl, input logic [key_w-1:0] exp_lvl,
                          input logic [7:0] hold_cycles);
    cur.key     = lvl;
    cur.exp_key = exp_lvl;
    push_step(hold_cycles);
  endtask

  // ==========================================================================
  // stimulus table
  // ==========================================================================
  task automatic build_table();
    logic [adc_w-1:0]  v1;
    logic [time_w-1:0] t1;
    cur           = '0;
    cur.key       = 2'b11;
    cur.exp_rst_n = 3'b111;
    cur.exp_key   = 2'b11;
    push_step(0);                         // reset values before the first edge
    // slow value reads and priority
    slow_read(32'h04, op_trig_offset);
    slow_read(32'h08, op_high_voltage);
    slow_read(32'h10, op_mean_offset);
    slow_read(32'h00, op_none);
    slow_read(32'h1c, op_trig_offset);    // trig beats hv and mean
    slow_read(32'h18, op_high_voltage);   // hv beats mean
    // sample then read, release ack, read again once consumed
    cur.cmd     = 32'h00;
    cur.exp_hps = '0;
    new_sample();
    v1 = cur.val;
    t1 = cur.tim;
    push_step(2);
    cur.cmd     = 32'h03;                 // sample with ack
    cur.exp_hps = sample_word(v1, t1);
    push_step(1);
    cur.cmd = 32'h01;                     // ack low holds word
    push_step(2);
    cur.cmd     = 32'h03;
    cur.exp_hps = '0;                     // consumed
    push_step(1);
    cur.cmd = 32'h00;
    push_step(2);
    // two samples with no ack between them
    new_sample();
    push_step(1);
    new_sample();
    v1 = cur.val;
    t1 = cur.tim;
    push_step(2);
    cur.cmd     = 32'h03;
    cur.exp_hps = sample_word(v1, t1);    // newest one
    push_step(1);
    cur.cmd     = 32'h00;
    cur.exp_hps = '0;
    push_step(2);
    // cold pulse of 6 cycles with a retrigger inside
    req_step(rst_cold, 1'b1, 1'b0, 1);
    req_step(rst_cold, 1'b0, 1'b0, 1);
    req_step(rst_cold, 1'b1, 1'b0, 3);    // edge ignored
    req_step(rst_cold, 1'b1, 1'b0, 1);    // last low cycle
    req_step(rst_cold, 1'b1, 1'b1, 1);
    req_step(rst_cold, 1'b0, 1'b1, 1);
    // warm pulse of 2 cycles
    req_step(rst_warm, 1'b1, 1'b0, 1);
    req_step(rst_warm, 1'b1, 1'b0, 1);
    req_step(rst_warm, 1'b1, 1'b1, 1);
    req_step(rst_warm, 1'b0, 1'b1, 1);
    // debug pulse of 32 cycles with a retrigger inside
    req_step(rst_debug, 1'b1, 1'b0, 1);
    req_step(rst_debug, 1'b0, 1'b0, 4);
    req_step(rst_debug, 1'b1, 1'b0, 26);
    req_step(rst_debug, 1'b1, 1'b0, 1);   // cycle 32 still low
    req_step(rst_debug, 1'b1, 1'b1, 1);
    req_step(rst_debug, 1'b0, 1'b1, 1);
    // key glitch then a real press and release
    key_step(2'b10, 2'b11, 10);
    key_step(2'b11, 2'b11, 5);
    key_step(2'b10, 2'b11, 16);           // not yet
    key_step(2'b10, 2'b10, 2);            // by cycle 18
    key_step(2'b11, 2'b10, 16);
    key_step(2'b11, 2'b11, 2);
    key_step(2'b01, 2'b11, 15);           // glitch on key 1
    key_step(2'b11, 2'b11, 2);
  endtask

  // ==========================================================================
  // watchdog
  // ==========================================================================
  always @(posedge CLOCK_80MHZ)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit)
    begin
      $display("timeout after %0d cycles, table did not finish", cycle_cnt);
      $display("checks %0d, errors %0d", checks, errors + 1);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ==========================================================================
  // main sequence
  // ==========================================================================
  initial
  begin
    int total;
    hps_fpga_reset_n = 1'b0;
    new_data         = 1'b0;
    adc_value        = '0;
    adc_time         = '0;
    hps_cmd          = '0;
    trig_offset      = '0;
    high_voltage     = '0;
    mean_offset      = '0;
    reset_req        = '0;
    key              = 2'b11;  // released
    build_table();
    total = 0;
    foreach (steps[i])
      total += steps[i].hold;
    cycle_limit = total + 200;
    repeat (3) @(posedge CLOCK_80MHZ);
    @(negedge CLOCK_80MHZ);
    hps_fpga_reset_n = 1'b1;
    for (int i = 0; i < steps.size(); i++)
    begin
      st           = steps[i];
      hps_cmd      = st.cmd;
      trig_offset  = st.trig;
      high_voltage = st.hv;
      mean_offset  = st.mean;
      new_data     = st.nd;
      adc_value    = st.val;
      adc_time     = st.tim;
      reset_req    = st.rreq;
      key          = st.key;
      for (int h = 0; h < st.hold; h++)
      begin
        @(posedge CLOCK_80MHZ);
        @(negedge CLOCK_80MHZ);
        new_data = 1'b0;
      end
      checks++;
      if (to_hps !== st.exp_hps)
      begin
        errors++;
        $display("error at %0t: to_hps expected %h, got %h (step %0d)",
                 $time, st.exp_hps, to_hps, i);
      end
      if (cold_reset_req_n !== st.exp_rst_n[rst_cold])
      begin
        errors++;
        $display("error at %0t: cold_reset_req_n expected %b, got %b (step %0d)",
                 $time, st.exp_rst_n[rst_cold], cold_reset_req_n, i);
      end
      if (warm_reset_req_n !== st.exp_rst_n[rst_warm])
      begin
        errors++;
        $display("error at %0t: warm_reset_req_n expected %b, got %b (step %0d)",
                 $time, st.exp_rst_n[rst_warm], warm_reset_req_n, i);
      end
      if (debug_reset_req_n !== st.exp_rst_n[rst_debug])
      begin
        errors++;
        $display("error at %0t: debug_reset_req_n expected %b, got %b (step %0d)",
                 $time, st.exp_rst_n[rst_debug], debug_reset_req_n, i);
      end
      if (key_clean !== st.exp_key)
      begin
        errors++;
        $display("error at %0t: key_clean expected %b, got %b (step %0d)",
                 $time, st.exp_key, key_clean, i);
      end
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
